// ==== mem_island_addr_pkg.sv ====
/*
  Byte address layout of the memory island, fixed at 12 bits.
  Narrow view: row | wide bank | sub-bank | byte offset (2 bits).
  Wide view:   row | wide bank | byte offset (3 bits).
*/
package mem_island_addr_pkg;

  localparam int AddrWidth      = 12;
  localparam int RowWidth       = 8;
  localparam int NumWideBanks   = 2;
  localparam int NumSubBanks    = 2;
  localparam int NumBanks       = NumWideBanks * NumSubBanks;

  localparam int WideSelWidth   = $clog2(NumWideBanks);
  localparam int SubSelWidth    = $clog2(NumSubBanks);
  localparam int BankSelWidth   = WideSelWidth + SubSelWidth;
  localparam int NarrowOffWidth = 2;
  localparam int WideOffWidth   = 3;

  typedef struct packed {
    logic [RowWidth-1:0]       row;
    logic [WideSelWidth-1:0]   wide_bank;
    logic [SubSelWidth-1:0]    sub_bank;
    logic [NarrowOffWidth-1:0] byte_off;
  } narrow_addr_t;

  typedef struct packed {
    logic [RowWidth-1:0]     row;
    logic [WideSelWidth-1:0] wide_bank;
    logic [WideOffWidth-1:0] byte_off;
  } wide_addr_t;

  // Same 12 address bits, decoded per port width
  typedef union packed {
    narrow_addr_t narrow;
    wide_addr_t   wide;
  } island_addr_u;

endpackage

// ==== mem_island_bus_pkg.sv ====
/*
  Request and bank access types of the req/gnt/rvalid memory protocol.
  Wide data is two narrow words, sub-bank 0 in the low half.
*/
package mem_island_bus_pkg;

  localparam int NarrowWidth     = 32;
  localparam int WideWidth       = 64;
  localparam int NarrowStrbWidth = NarrowWidth / 8;
  localparam int WideStrbWidth   = WideWidth / 8;

  typedef struct packed {
    logic [mem_island_addr_pkg::AddrWidth-1:0] addr;
    logic                                      we;
    logic [NarrowWidth-1:0]                    wdata;
    logic [NarrowStrbWidth-1:0]                strb;
  } narrow_req_t;

  typedef struct packed {
    logic [mem_island_addr_pkg::AddrWidth-1:0] addr;
    logic                                      we;
    logic [WideWidth-1:0]                      wdata;
    logic [WideStrbWidth-1:0]                  strb;
  } wide_req_t;

  // What a single sub-bank sees
  typedef struct packed {
    logic [mem_island_addr_pkg::RowWidth-1:0] row;
    logic                                     we;
    logic [NarrowWidth-1:0]                   wdata;
    logic [NarrowStrbWidth-1:0]               strb;
  } bank_acc_t;

  typedef struct packed {
    logic                                         valid;
    logic [mem_island_addr_pkg::WideSelWidth-1:0] wide_bank;
    logic [mem_island_addr_pkg::SubSelWidth-1:0]  sub_bank;
  } narrow_sel_t;

endpackage

// ==== req_decode.sv ====
/*
  Combinational address decode for both ports.
  Bank index is wide_bank * NumSubBanks + sub_bank.
  Access fields are broadcast, only the request lines are steered.
*/
`timescale 1ns/1ps

module req_decode (
  input  logic                                  narrow_req_i,
  input  mem_island_bus_pkg::narrow_req_t       narrow_bus_i,
  input  logic                                  wide_req_i,
  input  mem_island_bus_pkg::wide_req_t         wide_bus_i,
  output logic [mem_island_addr_pkg::NumBanks-1:0] narrow_bank_req_o,
  output mem_island_bus_pkg::bank_acc_t [mem_island_addr_pkg::NumBanks-1:0] narrow_acc_o,
  output logic [mem_island_addr_pkg::NumWideBanks-1:0] wide_bank_req_o,
  output mem_island_bus_pkg::bank_acc_t [mem_island_addr_pkg::NumWideBanks-1:0]
                                        [mem_island_addr_pkg::NumSubBanks-1:0] wide_acc_o,
  output mem_island_bus_pkg::narrow_sel_t       narrow_sel_o
);

  mem_island_addr_pkg::island_addr_u              narrow_addr;
  mem_island_addr_pkg::island_addr_u              wide_addr;
  logic [mem_island_addr_pkg::BankSelWidth-1:0]   narrow_bank;
  mem_island_bus_pkg::bank_acc_t                  narrow_acc;

  assign narrow_addr = narrow_bus_i.addr;
  assign wide_addr   = wide_bus_i.addr;
  assign narrow_bank = {narrow_addr.narrow.wide_bank, narrow_addr.narrow.sub_bank};

  always_comb begin
    narrow_acc.row   = narrow_addr.narrow.row;
    narrow_acc.we    = narrow_bus_i.we;
    narrow_acc.wdata = narrow_bus_i.wdata;
    narrow_acc.strb  = narrow_bus_i.strb;
  end

  always_comb begin
    for (int k = 0; k < mem_island_addr_pkg::NumBanks; k++) begin
      narrow_bank_req_o[k] = narrow_req_i &&
                             (narrow_bank == mem_island_addr_pkg::BankSelWidth'(k));
      narrow_acc_o[k]      = narrow_acc;
    end
  end

  // Read data is later picked by this selection
  always_comb begin
    narrow_sel_o.valid     = narrow_req_i;
    narrow_sel_o.wide_bank = narrow_addr.narrow.wide_bank;
    narrow_sel_o.sub_bank  = narrow_addr.narrow.sub_bank;
  end

  // Wide word split into one narrow slice per sub-bank
  always_comb begin
    for (int w = 0; w < mem_island_addr_pkg::NumWideBanks; w++) begin
      wide_bank_req_o[w] = wide_req_i &&
                           (wide_addr.wide.wide_bank == mem_island_addr_pkg::WideSelWidth'(w));
      for (int s = 0; s < mem_island_addr_pkg::NumSubBanks; s++) begin
        wide_acc_o[w][s].row   = wide_addr.wide.row;
        wide_acc_o[w][s].we    = wide_bus_i.we;
        wide_acc_o[w][s].wdata =
          wide_bus_i.wdata[s*mem_island_bus_pkg::NarrowWidth +: mem_island_bus_pkg::NarrowWidth];
        wide_acc_o[w][s].strb  =
          wide_bus_i.strb[s*mem_island_bus_pkg::NarrowStrbWidth +:
                          mem_island_bus_pkg::NarrowStrbWidth];
      end
    end
  end

endmodule

// ==== bank_arbiter.sv ====
/*
  Narrow-first arbitration for the sub-banks of one wide bank.
  After WidePriorityWait lost cycles wide may take a sub-bank, 0 disables this.
  Wide is granted only with all sub-banks at once, otherwise narrow keeps them.
*/
`timescale 1ns/1ps

module bank_arbiter #(
  parameter int WidePriorityWait = 0
) (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic [mem_island_addr_pkg::NumSubBanks-1:0]                 narrow_req_i,
  input  mem_island_bus_pkg::bank_acc_t [mem_island_addr_pkg::NumSubBanks-1:0] narrow_acc_i,
  input  logic                                                        wide_req_i,
  input  mem_island_bus_pkg::bank_acc_t [mem_island_addr_pkg::NumSubBanks-1:0] wide_acc_i,
  output logic [mem_island_addr_pkg::NumSubBanks-1:0]                 narrow_win_o,
  output logic                                                        wide_gnt_o,
  output logic [mem_island_addr_pkg::NumSubBanks-1:0]                 bank_en_o,
  output mem_island_bus_pkg::bank_acc_t [mem_island_addr_pkg::NumSubBanks-1:0] bank_acc_o
);

  localparam int CntWidth = (WidePriorityWait > 0) ? $clog2(WidePriorityWait + 1) : 1;
  localparam logic [CntWidth-1:0] WaitLimit = CntWidth'(WidePriorityWait);

  logic [mem_island_addr_pkg::NumSubBanks-1:0][CntWidth-1:0] cnt_q;
  logic [mem_island_addr_pkg::NumSubBanks-1:0][CntWidth-1:0] cnt_d;
  logic [mem_island_addr_pkg::NumSubBanks-1:0]               conflict;
  logic [mem_island_addr_pkg::NumSubBanks-1:0]               wide_turn;
  logic [mem_island_addr_pkg::NumSubBanks-1:0]               wide_hold;

  always_comb begin
    for (int s = 0; s < mem_island_addr_pkg::NumSubBanks; s++) begin
      conflict[s]  = narrow_req_i[s] & wide_req_i;
      wide_turn[s] = (WidePriorityWait != 0) && (cnt_q[s] == WaitLimit);
      // Wide holds a sub-bank when it is free or when its turn has come
      wide_hold[s] = wide_req_i & (~narrow_req_i[s] | wide_turn[s]);
    end
  end

  assign wide_gnt_o = &wide_hold;

  always_comb begin
    for (int s = 0; s < mem_island_addr_pkg::NumSubBanks; s++) begin
      narrow_win_o[s] = narrow_req_i[s] & ~wide_gnt_o;
      bank_en_o[s]    = narrow_win_o[s] | wide_gnt_o;
      bank_acc_o[s]   = wide_gnt_o ? wide_acc_i[s] : narrow_acc_i[s];
    end
  end

  // Counter waits at the limit until the other sub-bank lets wide in too
  always_comb begin
    for (int s = 0; s < mem_island_addr_pkg::NumSubBanks; s++) begin
      if (!conflict[s] || wide_gnt_o) begin
        cnt_d[s] = '0;
      end else if (cnt_q[s] != WaitLimit) begin
        cnt_d[s] = cnt_q[s] + 1'b1;
      end else begin
        cnt_d[s] = cnt_q[s];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// ==== sram_bank.sv ====
/*
  Single-port 256x32 bank with byte write enables.
  Read data is registered and only changes on an enabled cycle.
  A write returns the word as it was before the write.
*/
`timescale 1ns/1ps

module sram_bank (
  input  logic                                      clk_i,
  input  logic                                      en_i,
  input  mem_island_bus_pkg::bank_acc_t             acc_i,
  output logic [mem_island_bus_pkg::NarrowWidth-1:0] rdata_o
);

  localparam int NumWords = 2 ** mem_island_addr_pkg::RowWidth;

  logic [mem_island_bus_pkg::NarrowWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (acc_i.we) begin
        for (int b = 0; b < mem_island_bus_pkg::NarrowStrbWidth; b++) begin
          if (acc_i.strb[b]) begin
            mem_q[acc_i.row][8*b +: 8] <= acc_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_o <= mem_q[acc_i.row];
    end
  end

endmodule

// ==== rsp_collect.sv ====
/*
  One register stage that remembers which banks served the accepted accesses.
  Assumes at most one wide bank is granted per cycle.
*/
`timescale 1ns/1ps

module rsp_collect (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  mem_island_bus_pkg::narrow_sel_t                 narrow_sel_i,
  input  logic                                            narrow_gnt_i,
  input  logic [mem_island_addr_pkg::NumWideBanks-1:0]    wide_gnt_i,
  input  logic [mem_island_addr_pkg::NumBanks-1:0][mem_island_bus_pkg::NarrowWidth-1:0]
                                                          bank_rdata_i,
  output logic                                            narrow_rvalid_o,
  output logic [mem_island_bus_pkg::NarrowWidth-1:0]      narrow_rdata_o,
  output logic                                            wide_rvalid_o,
  output logic [mem_island_bus_pkg::WideWidth-1:0]        wide_rdata_o
);

  mem_island_bus_pkg::narrow_sel_t              narrow_sel_d;
  mem_island_bus_pkg::narrow_sel_t              narrow_sel_q;
  logic [mem_island_addr_pkg::WideSelWidth-1:0] wide_bank_d;
  logic [mem_island_addr_pkg::WideSelWidth-1:0] wide_bank_q;
  logic                                         wide_valid_q;

  always_comb begin
    narrow_sel_d       = narrow_sel_i;
    narrow_sel_d.valid = narrow_sel_i.valid & narrow_gnt_i;
  end

  // One-hot grant to bank index
  always_comb begin
    wide_bank_d = '0;
    for (int w = 0; w < mem_island_addr_pkg::NumWideBanks; w++) begin
      if (wide_gnt_i[w]) begin
        wide_bank_d = mem_island_addr_pkg::WideSelWidth'(w);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      narrow_sel_q <= '0;
      wide_bank_q  <= '0;
      wide_valid_q <= 1'b0;
    end else begin
      narrow_sel_q <= narrow_sel_d;
      wide_bank_q  <= wide_bank_d;
      wide_valid_q <= |wide_gnt_i;
    end
  end

  assign narrow_rvalid_o = narrow_sel_q.valid;
  assign narrow_rdata_o  = bank_rdata_i[{narrow_sel_q.wide_bank, narrow_sel_q.sub_bank}];
  assign wide_rvalid_o   = wide_valid_q;

  // Sub-bank 1 lands in the high half
  always_comb begin
    for (int s = 0; s < mem_island_addr_pkg::NumSubBanks; s++) begin
      wide_rdata_o[s*mem_island_bus_pkg::NarrowWidth +: mem_island_bus_pkg::NarrowWidth] =
        bank_rdata_i[{wide_bank_q, mem_island_addr_pkg::SubSelWidth'(s)}];
    end
  end

endmodule

// ==== mem_island_top.sv ====
/*
  Memory island with one 32-bit and one 64-bit req/gnt/rvalid port over four banks.
  Fixed latency, rvalid follows every accepted access by one cycle, no back-pressure.
  Narrow has priority, wide wins a sub-bank after WidePriorityWait lost cycles.
*/
`timescale 1ns/1ps

module mem_island_top #(
  parameter int WidePriorityWait = 3
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       narrow_req_i,
  input  mem_island_bus_pkg::narrow_req_t            narrow_bus_i,
  output logic                                       narrow_gnt_o,
  output logic                                       narrow_rvalid_o,
  output logic [mem_island_bus_pkg::NarrowWidth-1:0] narrow_rdata_o,
  input  logic                                       wide_req_i,
  input  mem_island_bus_pkg::wide_req_t              wide_bus_i,
  output logic                                       wide_gnt_o,
  output logic                                       wide_rvalid_o,
  output logic [mem_island_bus_pkg::WideWidth-1:0]   wide_rdata_o
);

  localparam int NumBanks     = mem_island_addr_pkg::NumBanks;
  localparam int NumWideBanks = mem_island_addr_pkg::NumWideBanks;
  localparam int NumSubBanks  = mem_island_addr_pkg::NumSubBanks;

  logic [NumBanks-1:0]                                     narrow_bank_req;
  mem_island_bus_pkg::bank_acc_t [NumBanks-1:0]            narrow_acc;
  logic [NumWideBanks-1:0]                                 wide_bank_req;
  mem_island_bus_pkg::bank_acc_t [NumWideBanks-1:0][NumSubBanks-1:0] wide_acc;
  mem_island_bus_pkg::narrow_sel_t                         narrow_sel;
  logic [NumBanks-1:0]                                     narrow_win;
  logic [NumWideBanks-1:0]                                 wide_gnt;
  logic [NumBanks-1:0]                                     bank_en;
  mem_island_bus_pkg::bank_acc_t [NumBanks-1:0]            bank_acc;
  logic [NumBanks-1:0][mem_island_bus_pkg::NarrowWidth-1:0] bank_rdata;

  assign narrow_gnt_o = |narrow_win;
  assign wide_gnt_o   = |wide_gnt;

  req_decode i_req_decode (
    .narrow_req_i      ( narrow_req_i    ),
    .narrow_bus_i      ( narrow_bus_i    ),
    .wide_req_i        ( wide_req_i      ),
    .wide_bus_i        ( wide_bus_i      ),
    .narrow_bank_req_o ( narrow_bank_req ),
    .narrow_acc_o      ( narrow_acc      ),
    .wide_bank_req_o   ( wide_bank_req   ),
    .wide_acc_o        ( wide_acc        ),
    .narrow_sel_o      ( narrow_sel      )
  );

  for (genvar w = 0; w < NumWideBanks; w++) begin : gen_arbiter
    bank_arbiter #(
      .WidePriorityWait ( WidePriorityWait )
    ) i_bank_arbiter (
      .clk_i        ( clk_i                                          ),
      .rst_ni       ( rst_ni                                         ),
      .narrow_req_i ( narrow_bank_req[w*NumSubBanks +: NumSubBanks] ),
      .narrow_acc_i ( narrow_acc[w*NumSubBanks +: NumSubBanks]      ),
      .wide_req_i   ( wide_bank_req[w]                               ),
      .wide_acc_i   ( wide_acc[w]                                    ),
      .narrow_win_o ( narrow_win[w*NumSubBanks +: NumSubBanks]      ),
      .wide_gnt_o   ( wide_gnt[w]                                    ),
      .bank_en_o    ( bank_en[w*NumSubBanks +: NumSubBanks]         ),
      .bank_acc_o   ( bank_acc[w*NumSubBanks +: NumSubBanks]        )
    );
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    sram_bank i_sram_bank (
      .clk_i   ( clk_i         ),
      .en_i    ( bank_en[b]    ),
      .acc_i   ( bank_acc[b]   ),
      .rdata_o ( bank_rdata[b] )
    );
  end

  rsp_collect i_rsp_collect (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .narrow_sel_i    ( narrow_sel      ),
    .narrow_gnt_i    ( narrow_gnt_o    ),
    .wide_gnt_i      ( wide_gnt        ),
    .bank_rdata_i    ( bank_rdata      ),
    .narrow_rvalid_o ( narrow_rvalid_o ),
    .narrow_rdata_o  ( narrow_rdata_o  ),
    .wide_rvalid_o   ( wide_rvalid_o   ),
    .wide_rdata_o    ( wide_rdata_o    )
  );

endmodule

// ==== mem_island_props.sv ====
/*
  Protocol checks bound onto the memory island top level.
  A response must follow an accepted request by exactly one cycle.
*/
`timescale 1ns/1ps

module mem_island_props (
  input logic clk_i,
  input logic rst_ni,
  input logic narrow_req_i,
  input logic narrow_gnt_o,
  input logic narrow_rvalid_o,
  input logic wide_req_i,
  input logic wide_gnt_o,
  input logic wide_rvalid_o
);

  // No response without an accepted request on the cycle before
  narrow_rvalid_needs_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    narrow_rvalid_o |-> $past(narrow_req_i && narrow_gnt_o)
  ) else $error("narrow rvalid seen without a narrow grant one cycle earlier");

  wide_rvalid_needs_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wide_rvalid_o |-> $past(wide_req_i && wide_gnt_o)
  ) else $error("wide rvalid seen without a wide grant one cycle earlier");

  // Both response lines quiet as reset ends
  rvalid_low_after_reset: assert property (
    @(posedge clk_i)
    $rose(rst_ni) |-> (!narrow_rvalid_o && !wide_rvalid_o)
  ) else $error("rvalid high on the first cycle after reset");

endmodule

bind mem_island_top mem_island_props i_mem_island_props (
  .clk_i           ( clk_i           ),
  .rst_ni          ( rst_ni          ),
  .narrow_req_i    ( narrow_req_i    ),
  .narrow_gnt_o    ( narrow_gnt_o    ),
  .narrow_rvalid_o ( narrow_rvalid_o ),
  .wide_req_i      ( wide_req_i      ),
  .wide_gnt_o      ( wide_gnt_o      ),
  .wide_rvalid_o   ( wide_rvalid_o   )
);

// ==== tb_mem_island.sv ====
/*
  Testbench for the memory island with WidePriorityWait = 3.
  A byte-wide reference memory predicts every response, outputs are sampled at rising edges.
*/
`timescale 1ns/1ps

module tb_mem_island;

  localparam int ResetLen  = 16;
  localparam int FillLen   = 520;
  localparam int MergeLen  = 140;
  localparam int SplitLen  = 20;
  localparam int ParLen    = 10;
  localparam int ConfLen   = 24;
  localparam int HoldLen   = 20;
  localparam int MaxCycles = ResetLen + FillLen + MergeLen + SplitLen + ParLen + ConfLen +
                             HoldLen + 100;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic narrow_req_i = 1'b0;
  mem_island_bus_pkg::narrow_req_t narrow_bus_i = '0;
  logic narrow_gnt_o;
  logic narrow_rvalid_o;
  logic [31:0] narrow_rdata_o;
  logic wide_req_i = 1'b0;
  mem_island_bus_pkg::wide_req_t wide_bus_i = '0;
  logic wide_gnt_o;
  logic wide_rvalid_o;
  logic [63:0] wide_rdata_o;

  logic [7:0]  ref_mem [4096];
  logic [31:0] narrow_exp [$];
  logic [63:0] wide_exp [$];
  logic [31:0] lfsr = 32'd55;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  mem_island_top #(
    .WidePriorityWait ( 3 )
  ) mem_island_top_i (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Run stopped after %0d cycles, a transfer never completed", cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Every response arrives one cycle after its grant
  narrow_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (narrow_req_i && narrow_gnt_o) |=> narrow_rvalid_o)
    else begin
      $display("narrow rvalid missing one cycle after a grant");
      errors++;
    end

  wide_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wide_req_i && wide_gnt_o) |=> wide_rvalid_o)
    else begin
      $display("wide rvalid missing one cycle after a grant");
      errors++;
    end

  // Flops update with nonblocking writes, so these are the values before the edge
  always @(posedge clk_i) begin
    logic [11:0] base;
    logic [31:0] nexp;
    logic [63:0] wexp;
    if (rst_ni) begin
      if (narrow_rvalid_o) begin
        checks++;
        nexp = narrow_exp.pop_front();
        assert (narrow_rdata_o === nexp) else begin
          $display("[ERROR] narrow_rdata_o got %h expected %h", narrow_rdata_o, nexp);
          errors++;
        end
      end
      if (wide_rvalid_o) begin
        checks++;
        wexp = wide_exp.pop_front();
        assert (wide_rdata_o === wexp) else begin
          $display("[ERROR] wide_rdata_o got %h expected %h", wide_rdata_o, wexp);
          errors++;
        end
      end
      if (narrow_req_i && narrow_gnt_o) begin
        base = narrow_bus_i.addr & 12'hffc;
        for (int b = 0; b < 4; b++) begin
          nexp[8*b +: 8] = ref_mem[base + 12'(b)];
          if (narrow_bus_i.we && narrow_bus_i.strb[b]) begin
            ref_mem[base + 12'(b)] = narrow_bus_i.wdata[8*b +: 8];
          end
        end
        narrow_exp.push_back(nexp);
      end
      if (wide_req_i && wide_gnt_o) begin
        base = wide_bus_i.addr & 12'hff8;
        for (int b = 0; b < 8; b++) begin
          wexp[8*b +: 8] = ref_mem[base + 12'(b)];
          if (wide_bus_i.we && wide_bus_i.strb[b]) begin
            ref_mem[base + 12'(b)] = wide_bus_i.wdata[8*b +: 8];
          end
        end
        wide_exp.push_back(wexp);
      end
    end
  end

  task automatic narrow_xfer(input logic [11:0] addr, input logic we,
                             input logic [31:0] wdata, input logic [3:0] strb);
    @(negedge clk_i);
    narrow_req_i = 1'b1;
    narrow_bus_i = '{addr: addr, we: we, wdata: wdata, strb: strb};
    @(posedge clk_i);
    while (!narrow_gnt_o) @(posedge clk_i);
  endtask

  task automatic wide_xfer(input logic [11:0] addr, input logic we,
                           input logic [63:0] wdata, input logic [7:0] strb);
    @(negedge clk_i);
    wide_req_i = 1'b1;
    wide_bus_i = '{addr: addr, we: we, wdata: wdata, strb: strb};
    @(posedge clk_i);
    while (!wide_gnt_o) @(posedge clk_i);
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    narrow_req_i = 1'b0;
    wide_req_i   = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, errors so far %0d", name, errors);
  endtask

  initial begin
    logic [11:0] addrs [32];
    logic [63:0] r;
    int          w_cnt;
    logic        wide_due;
    repeat (ResetLen) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Whole array written so that every later read is defined
    for (int a = 0; a < 512; a++) begin
      wide_xfer(12'(a * 8), 1'b1, rand_bits(64), 8'hff);
    end
    go_idle();
    finish_test("fill");

    for (int i = 0; i < 32; i++) begin
      r = rand_bits(10);
      addrs[i] = {r[9:0], 2'b00};
      narrow_xfer(addrs[i], 1'b1, 32'(rand_bits(32)), 4'(rand_bits(4)));
    end
    for (int i = 0; i < 32; i++) begin
      narrow_xfer(addrs[i], 1'b0, '0, '0);
    end
    go_idle();
    finish_test("narrow strobe merge");

    wide_xfer(12'h128, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff);
    go_idle();
    narrow_xfer(12'h128, 1'b0, '0, '0);
    narrow_xfer(12'h12c, 1'b0, '0, '0);
    narrow_xfer(12'h340, 1'b1, 32'hdead_beef, 4'hf);
    narrow_xfer(12'h344, 1'b1, 32'hcafe_f00d, 4'hf);
    go_idle();
    wide_xfer(12'h340, 1'b0, '0, '0);
    go_idle();
    finish_test("wide narrow split");

    @(negedge clk_i);
    narrow_req_i = 1'b1;
    narrow_bus_i = '{addr: 12'h204, we: 1'b0, wdata: '0, strb: '0};
    wide_req_i   = 1'b1;
    wide_bus_i   = '{addr: 12'h218, we: 1'b0, wdata: '0, strb: '0};
    @(posedge clk_i);
    assert (narrow_gnt_o && wide_gnt_o) else begin
      $display("narrow and wide requests to different wide banks were not both granted");
      errors++;
    end
    go_idle();
    finish_test("parallel wide banks");

    // Narrow keeps sub-bank 0 of wide bank 0 busy while wide waits for it
    @(negedge clk_i);
    narrow_req_i = 1'b1;
    narrow_bus_i = '{addr: 12'h060, we: 1'b0, wdata: '0, strb: '0};
    wide_req_i   = 1'b1;
    wide_bus_i   = '{addr: 12'h0a0, we: 1'b0, wdata: '0, strb: '0};
    for (int k = 0; k < 16; k++) begin
      @(posedge clk_i);
      wide_due = (k % 4) == 3;
      assert (wide_gnt_o == wide_due && narrow_gnt_o == !wide_due) else begin
        $display("[ERROR] cycle %0d wide_gnt_o %h narrow_gnt_o %h expected %h and %h",
                 k, wide_gnt_o, narrow_gnt_o, wide_due, !wide_due);
        errors++;
      end
    end
    go_idle();
    finish_test("conflict priority");

    w_cnt = 1;
    @(negedge clk_i);
    narrow_req_i = 1'b1;
    narrow_bus_i = '{addr: 12'h31c, we: 1'b0, wdata: '0, strb: '0};
    wide_req_i   = 1'b1;
    wide_bus_i   = '{addr: 12'h5d8, we: 1'b1, wdata: 64'h5a5a_0f0f_a5a5_f0f0, strb: 8'hff};
    @(posedge clk_i);
    while (!wide_gnt_o) begin
      w_cnt++;
      @(posedge clk_i);
    end
    assert (w_cnt == 4) else begin
      $display("[ERROR] wide_gnt_o came on cycle %h expected 4", w_cnt);
      errors++;
    end
    go_idle();
    wide_xfer(12'h5d8, 1'b0, '0, '0);
    go_idle();
    finish_test("held wide request");

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
mem_island_addr_pkg.sv
mem_island_bus_pkg.sv
req_decode.sv
bank_arbiter.sv
sram_bank.sv
rsp_collect.sv
mem_island_top.sv
mem_island_props.sv
tb_mem_island.sv

// ==== Makefile ====
SRCS := $(shell cat files.f)

.PHONY: run clean

obj_dir/Vtb_mem_island: $(SRCS) files.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_island \
		-f files.f -o Vtb_mem_island

run: obj_dir/Vtb_mem_island
	./obj_dir/Vtb_mem_island > sim.log 2>&1; cat sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
